//--- wbuf.f
logic/wbuf_pkg.sv
logic/wbuf_cfg_regs.sv
logic/wbuf_store.sv
logic/wbuf_loader.sv
logic/mac_row.sv
logic/wbuf_top.sv
verif/wbuf_tb.sv

//--- Makefile
TOOL       := verilator
FLAGS      := --binary --timing --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
TOP        := wbuf_tb
FILELIST   := wbuf.f
BUILD_DIR  := obj_dir
PASS_MSG   := No errors

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass message shows up on a line of its own
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- verif/wbuf_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wbuf_tb
  import wbuf_pkg::*;
();

  localparam int unsigned H            = DEF_H;
  localparam int unsigned D            = DEF_D;
  localparam int unsigned N_REGS       = DEF_N_REGS;
  localparam int unsigned C            = (D + N_REGS) / (N_REGS + 1);
  localparam int unsigned RESET_CYCLES = 3;

  typedef enum logic [1:0] {OP_IDLE, OP_CFG, OP_LOAD, OP_SHIFT} op_e;

  // Operand is {addr, data} for configuration writes
  typedef struct packed {
    op_e          op;
    logic [9:0]   operand;
    logic         check;
    logic [H-1:0] zero_mask;
  } step_t;

  logic          clk_i;
  logic          rst_ni;
  logic          cfg_we_i;
  cfg_addr_t     cfg_addr_i;
  cfg_data_t     cfg_wdata_i;
  logic          load_i;
  logic          shift_i;
  elem_t [D-1:0] w_row_i;
  elem_t         x_i;
  acc_t [H-1:0]  acc_o;
  logic          acc_valid_o;

  step_t       steps[$];
  logic [31:0] lfsr_q;
  int          errors;
  int          checks;
  int          cycle_count;
  int          cycle_limit;

  // Reference model state
  elem_t m_w [H][D];
  int    m_row;
  int    m_el;
  int    m_col;
  int    m_width;
  int    m_height;
  logic  m_clear;
  logic  s1_valid;
  elem_t s1_w [H];
  elem_t s1_x;
  acc_t  m_acc [H];
  logic  m_acc_valid;

  wbuf_top #(
    .H      (H),
    .D      (D),
    .N_REGS (N_REGS)
  ) UUT (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .load_i      (load_i),
    .shift_i     (shift_i),
    .w_row_i     (w_row_i),
    .x_i         (x_i),
    .acc_o       (acc_o),
    .acc_valid_o (acc_valid_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, errors so far: %0d", cycle_limit, errors);
      $display("Errors found");
      $finish;
    end
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One step per bit, zero is nudged to one so padding is visible
  task automatic next_elem(output elem_t e);
    for (int b = 0; b < ELEM_W; b++) begin
      e[b]   = lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
    end
    if (e == elem_t'(0)) begin
      e = elem_t'(1);
    end
  endtask

  task automatic add_step(input op_e op, input logic [9:0] operand, input logic check,
                          input logic [H-1:0] zero_mask);
    step_t s;
    s.op        = op;
    s.operand   = operand;
    s.check     = check;
    s.zero_mask = zero_mask;
    steps.push_back(s);
  endtask

  task automatic add_steps(input op_e op, input int n);
    for (int k = 0; k < n; k++) begin
      add_step(op, '0, 1'b0, '0);
    end
  endtask

  task automatic add_cfg(input cfg_addr_t addr, input cfg_data_t data);
    add_step(OP_CFG, {addr, data}, 1'b0, '0);
  endtask

  // Result of the last shift shows two cycles later
  task automatic add_result_check(input logic [H-1:0] zero_mask);
    add_step(OP_IDLE, '0, 1'b0, '0);
    add_step(OP_IDLE, '0, 1'b1, zero_mask);
  endtask

  task automatic build_table();
    // Default geometry, one product first, then the rest of the pass
    add_steps(OP_LOAD, H);
    add_steps(OP_SHIFT, 1);
    add_result_check('0);
    add_steps(OP_SHIFT, D - 1);
    add_result_check('0);
    // Clear in the middle of a pass, weights kept
    add_steps(OP_SHIFT, 3);
    add_steps(OP_IDLE, 1);
    add_cfg(CFG_ADDR_CMD, 8'h00);
    add_steps(OP_IDLE, 1);
    add_steps(OP_SHIFT, D);
    add_result_check('0);
    // Two passes back to back
    add_cfg(CFG_ADDR_CMD, 8'h5a);
    add_steps(OP_IDLE, 1);
    add_steps(OP_SHIFT, 2 * D);
    add_result_check('0);
    // Width 5
    add_cfg(CFG_ADDR_WIDTH, 8'd5);
    add_cfg(CFG_ADDR_CMD, 8'h00);
    add_steps(OP_IDLE, 1);
    add_steps(OP_LOAD, H);
    add_steps(OP_SHIFT, D);
    add_result_check('0);
    // Height 2, upper lanes must read zero
    add_cfg(CFG_ADDR_WIDTH, cfg_data_t'(D));
    add_cfg(CFG_ADDR_HEIGHT, 8'd2);
    add_cfg(CFG_ADDR_CMD, 8'h00);
    add_steps(OP_IDLE, 1);
    add_steps(OP_LOAD, H);
    add_steps(OP_SHIFT, D);
    add_result_check(4'b1100);
  endtask

  task automatic model_reset();
    for (int h = 0; h < H; h++) begin
      for (int d = 0; d < D; d++) begin
        m_w[h][d] = '0;
      end
      s1_w[h]  = '0;
      m_acc[h] = '0;
    end
    m_row       = 0;
    m_el        = 0;
    m_col       = 0;
    m_width     = D;
    m_height    = H;
    m_clear     = 1'b0;
    s1_valid    = 1'b0;
    s1_x        = '0;
    m_acc_valid = 1'b0;
  endtask

  // One clock edge of the reference, using the inputs sampled at that edge
  task automatic model_step();
    int   idx;
    logic clr;
    clr = m_clear;
    if (clr) begin
      for (int h = 0; h < H; h++) begin
        m_acc[h] = '0;
      end
      m_acc_valid = 1'b0;
    end else begin
      if (s1_valid) begin
        for (int h = 0; h < H; h++) begin
          m_acc[h] = m_acc[h] + acc_t'(s1_w[h]) * acc_t'(s1_x);
        end
      end
      m_acc_valid = s1_valid;
    end
    // Read sees the content from before a load on the same edge
    if (shift_i) begin
      idx = m_col * (N_REGS + 1) + m_el;
      for (int h = 0; h < H; h++) begin
        s1_w[h] = (idx < D) ? m_w[h][idx] : elem_t'(0);
      end
      s1_x = x_i;
    end
    s1_valid = shift_i;
    if (load_i) begin
      for (int d = 0; d < D; d++) begin
        m_w[m_row][d] = (d < m_width && m_row < m_height) ? w_row_i[d] : elem_t'(0);
      end
    end
    if (clr) begin
      m_row = 0;
      m_el  = 0;
      m_col = 0;
    end else begin
      if (load_i) begin
        m_row = (m_row == H - 1) ? 0 : m_row + 1;
      end
      if (shift_i) begin
        if (m_el == N_REGS) begin
          m_el  = 0;
          m_col = (m_col == C - 1) ? 0 : m_col + 1;
        end else begin
          m_el = m_el + 1;
        end
      end
    end
    m_clear = cfg_we_i && (cfg_addr_i == CFG_ADDR_CMD);
    if (cfg_we_i && cfg_addr_i == CFG_ADDR_WIDTH) begin
      m_width = cfg_wdata_i;
    end
    if (cfg_we_i && cfg_addr_i == CFG_ADDR_HEIGHT) begin
      m_height = cfg_wdata_i;
    end
  endtask

  task automatic apply_step(input step_t s);
    elem_t e;
    cfg_we_i = 1'b0;
    load_i   = 1'b0;
    shift_i  = 1'b0;
    x_i      = '0;
    case (s.op)
      OP_CFG: begin
        cfg_we_i    = 1'b1;
        cfg_addr_i  = s.operand[9:8];
        cfg_wdata_i = s.operand[7:0];
      end
      OP_LOAD: begin
        load_i = 1'b1;
        for (int d = 0; d < D; d++) begin
          next_elem(e);
          w_row_i[d] = e;
        end
      end
      OP_SHIFT: begin
        shift_i = 1'b1;
        next_elem(e);
        x_i = e;
      end
      default: begin
      end
    endcase
  endtask

  task automatic check_outputs(input int i, input step_t s);
    checks++;
    assert (acc_valid_o === m_acc_valid) else begin
      errors++;
      if (m_acc_valid) begin
        $display("Step %0d: a result was due but acc_valid_o is low", i);
      end else begin
        $display("Step %0d: acc_valid_o is high but no result is due", i);
      end
    end
    if (s.check) begin
      assert (acc_valid_o === 1'b1) else begin
        errors++;
        $display("Step %0d: no valid accumulator at the check point", i);
      end
    end
    if (acc_valid_o === 1'b1 && m_acc_valid) begin
      for (int h = 0; h < H; h++) begin
        assert (acc_o[h] === m_acc[h]) else begin
          errors++;
          $display("MISMATCH acc_o[%0d] step %0d: got %h expected %h", h, i, acc_o[h], m_acc[h]);
        end
        if (s.check && s.zero_mask[h]) begin
          assert (acc_o[h] === acc_t'(0)) else begin
            errors++;
            $display("MISMATCH acc_o[%0d] step %0d: got %h expected %h", h, i, acc_o[h],
                     acc_t'(0));
          end
        end
      end
    end
  endtask

  initial begin
    step_t idle;
    idle        = '0;
    errors      = 0;
    checks      = 0;
    cycle_count = 0;
    lfsr_q      = 32'ha706;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    load_i      = 1'b0;
    shift_i     = 1'b0;
    w_row_i     = '0;
    x_i         = '0;
    build_table();
    cycle_limit = steps.size() + 20;
    model_reset();
    repeat (RESET_CYCLES) begin
      @(posedge clk_i);
      #1;
      assert (acc_valid_o === 1'b0) else begin
        errors++;
        $display("acc_valid_o is high during reset");
      end
    end
    rst_ni = 1'b1;
    for (int i = 0; i < steps.size(); i++) begin
      @(posedge clk_i);
      #1;
      model_step();
      check_outputs(i, steps[i]);
      apply_step(steps[i]);
    end
    // Drain the last results through the MAC row
    repeat (2) begin
      @(posedge clk_i);
      #1;
      model_step();
      check_outputs(steps.size(), idle);
      apply_step(idle);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : wbuf_tb

`default_nettype wire

//--- logic/wbuf_top.sv
`timescale 1ns/1ps
`default_nettype none

module wbuf_top
  import wbuf_pkg::*;
#(
  parameter int unsigned H      = DEF_H,
  parameter int unsigned D      = DEF_D,
  parameter int unsigned N_REGS = DEF_N_REGS
) (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire logic          cfg_we_i,
  input  wire cfg_addr_t     cfg_addr_i,
  input  wire cfg_data_t     cfg_wdata_i,
  input  wire logic          load_i,
  input  wire logic          shift_i,
  input  wire elem_t [D-1:0] w_row_i,
  input  wire elem_t         x_i,
  output acc_t [H-1:0]       acc_o,
  output logic               acc_valid_o
);

  wbuf_geom_t    geom;
  wbuf_cmd_t     cmd;
  logic          clear;
  elem_t [H-1:0] w_read;
  logic          w_read_valid;
  elem_t         x_q;

  assign cmd.load  = load_i;
  assign cmd.shift = shift_i;

  wbuf_cfg_regs #(
    .H (H),
    .D (D)
  ) u_cfg_regs (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .we_i    (cfg_we_i),
    .addr_i  (cfg_addr_i),
    .wdata_i (cfg_wdata_i),
    .geom_o  (geom),
    .clear_o (clear)
  );

  wbuf_loader #(
    .H      (H),
    .D      (D),
    .N_REGS (N_REGS)
  ) u_loader (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clear_i   (clear),
    .geom_i    (geom),
    .cmd_i     (cmd),
    .w_row_i   (w_row_i),
    .w_o       (w_read),
    .w_valid_o (w_read_valid)
  );

  // Activation delayed to meet the registered weight read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_q <= '0;
    end else begin
      x_q <= x_i;
    end
  end

  mac_row #(
    .H (H)
  ) u_mac_row (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear),
    .w_i         (w_read),
    .w_valid_i   (w_read_valid),
    .x_i         (x_q),
    .acc_o       (acc_o),
    .acc_valid_o (acc_valid_o)
  );

endmodule : wbuf_top

`default_nettype wire

//--- logic/mac_row.sv
`timescale 1ns/1ps
`default_nettype none

module mac_row
  import wbuf_pkg::*;
#(
  parameter int unsigned H = DEF_H
) (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire logic          clear_i,
  input  wire elem_t [H-1:0] w_i,
  input  wire logic          w_valid_i,
  input  wire elem_t         x_i,
  output acc_t [H-1:0]       acc_o,
  output logic               acc_valid_o
);

  logic signed [2*ELEM_W-1:0] prod [H];
  acc_t [H-1:0]               acc_q;
  logic                       acc_valid_q;

  // One signed multiplier per lane, activation is broadcast
  for (genvar h = 0; h < H; h++) begin : gen_lane
    assign prod[h] = $signed(w_i[h]) * $signed(x_i);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0;
    end else if (w_valid_i) begin
      for (int h = 0; h < H; h++) begin
        acc_q[h] <= acc_q[h] + acc_t'(prod[h]);
      end
    end
  end

  // Valid trails the weight valid by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_valid_q <= 1'b0;
    end else begin
      acc_valid_q <= w_valid_i && !clear_i;
    end
  end

  assign acc_o       = acc_q;
  assign acc_valid_o = acc_valid_q;

endmodule : mac_row

`default_nettype wire

//--- logic/wbuf_loader.sv
`timescale 1ns/1ps
`default_nettype none

module wbuf_loader
  import wbuf_pkg::*;
#(
  parameter int unsigned H      = DEF_H,
  parameter int unsigned D      = DEF_D,
  parameter int unsigned N_REGS = DEF_N_REGS
) (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire logic          clear_i,
  input  wire wbuf_geom_t    geom_i,
  input  wire wbuf_cmd_t     cmd_i,
  input  wire elem_t [D-1:0] w_row_i,
  output elem_t [H-1:0]      w_o,
  output logic               w_valid_o
);

  // Columns of N_REGS+1 elements each
  localparam int unsigned C     = (D + N_REGS) / (N_REGS + 1);
  localparam int unsigned ROW_W = (H > 1) ? $clog2(H) : 1;
  localparam int unsigned EL_W  = (N_REGS > 0) ? $clog2(N_REGS + 1) : 1;
  localparam int unsigned COL_W = (C > 1) ? $clog2(C) : 1;
  localparam int unsigned IDX_W = ((D > 1) ? $clog2(D) : 1) + 1;

  logic [ROW_W-1:0] row_q;
  logic [EL_W-1:0]  el_q;
  logic [COL_W-1:0] col_q;
  logic             el_wrap;
  logic             col_wrap;
  logic             row_in_range;
  logic [IDX_W-1:0] read_idx;
  elem_t [D-1:0]    row_padded;

  // Zero padding outside the programmed width and height
  assign row_in_range = (row_q < geom_i.height);

  for (genvar d = 0; d < D; d++) begin : gen_pad
    assign row_padded[d] = ((d < geom_i.width) && row_in_range) ? w_row_i[d] : elem_t'(0);
  end

  // Row write counter, wraps after the last row
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_q <= '0;
    end else if (clear_i) begin
      row_q <= '0;
    end else if (cmd_i.load) begin
      if (row_q == ROW_W'(H - 1)) begin
        row_q <= '0;
      end else begin
        row_q <= row_q + 1'b1;
      end
    end
  end

  // Element/column read position
  assign el_wrap  = (el_q == EL_W'(N_REGS));
  assign col_wrap = (col_q == COL_W'(C - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      el_q  <= '0;
      col_q <= '0;
    end else if (clear_i) begin
      el_q  <= '0;
      col_q <= '0;
    end else if (cmd_i.shift) begin
      if (el_wrap) begin
        el_q  <= '0;
        col_q <= col_wrap ? '0 : col_q + 1'b1;
      end else begin
        el_q <= el_q + 1'b1;
      end
    end
  end

  assign read_idx = IDX_W'(col_q * (N_REGS + 1) + el_q);

  wbuf_store #(
    .H (H),
    .D (D)
  ) u_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .write_en_i  (cmd_i.load),
    .write_row_i (row_q),
    .wdata_i     (row_padded),
    .read_en_i   (cmd_i.shift),
    .read_idx_i  (read_idx),
    .rdata_o     (w_o),
    .rvalid_o    (w_valid_o)
  );

endmodule : wbuf_loader

`default_nettype wire

//--- logic/wbuf_store.sv
`timescale 1ns/1ps
`default_nettype none

module wbuf_store
  import wbuf_pkg::*;
#(
  parameter int unsigned H = DEF_H,
  parameter int unsigned D = DEF_D
) (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  input  wire logic                                   write_en_i,
  input  wire logic [((H > 1) ? $clog2(H) : 1)-1:0]   write_row_i,
  input  wire elem_t [D-1:0]                          wdata_i,
  input  wire logic                                   read_en_i,
  input  wire logic [((D > 1) ? $clog2(D) : 1):0]     read_idx_i,
  output elem_t [H-1:0]                               rdata_o,
  output logic                                        rvalid_o
);

  localparam int unsigned SEL_W = (D > 1) ? $clog2(D) : 1;

  elem_t [H-1:0][D-1:0] mem_q;
  elem_t [H-1:0]        rdata_q;
  logic                 rvalid_q;
  logic [SEL_W-1:0]     sel;
  logic                 idx_in_range;

  // Index may run past D when C*(N_REGS+1) exceeds the row length
  assign sel          = read_idx_i[SEL_W-1:0];
  assign idx_in_range = (read_idx_i < D);

  // Full-row write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else if (write_en_i) begin
      mem_q[write_row_i] <= wdata_i;
    end
  end

  // Registered read of one element from every row
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (read_en_i) begin
      for (int h = 0; h < H; h++) begin
        rdata_q[h] <= idx_in_range ? mem_q[h][sel] : elem_t'(0);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= read_en_i;
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule : wbuf_store

`default_nettype wire

//--- logic/wbuf_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wbuf_cfg_regs
  import wbuf_pkg::*;
#(
  parameter int unsigned H = DEF_H,
  parameter int unsigned D = DEF_D
) (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       we_i,
  input  wire cfg_addr_t  addr_i,
  input  wire cfg_data_t  wdata_i,
  output wbuf_geom_t      geom_o,
  output logic            clear_o
);

  wbuf_geom_t geom_q;
  logic       clear_q;

  // Geometry registers, reset to the full array
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      geom_q.width  <= cfg_data_t'(D);
      geom_q.height <= cfg_data_t'(H);
    end else if (we_i) begin
      case (addr_i)
        CFG_ADDR_WIDTH:  geom_q.width  <= wdata_i;
        CFG_ADDR_HEIGHT: geom_q.height <= wdata_i;
        default: begin
          // Command and unused addresses leave the geometry alone
        end
      endcase
    end
  end

  // Command write gives a single-cycle clear on the next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clear_q <= 1'b0;
    end else begin
      clear_q <= we_i && (addr_i == CFG_ADDR_CMD);
    end
  end

  assign geom_o  = geom_q;
  assign clear_o = clear_q;

endmodule : wbuf_cfg_regs

`default_nettype wire

//--- logic/wbuf_pkg.sv
`default_nettype none

package wbuf_pkg;

  // Element and accumulator widths
  localparam int unsigned ELEM_W = 8;
  localparam int unsigned ACC_W  = 24;

  // Default geometry of the buffer and the MAC row
  localparam int unsigned DEF_H      = 4;
  localparam int unsigned DEF_D      = 8;
  localparam int unsigned DEF_N_REGS = 1;

  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // Configuration bus
  typedef logic [1:0] cfg_addr_t;
  typedef logic [7:0] cfg_data_t;

  localparam cfg_addr_t CFG_ADDR_WIDTH  = 2'd0;
  localparam cfg_addr_t CFG_ADDR_HEIGHT = 2'd1;
  // Any write here issues a clear
  localparam cfg_addr_t CFG_ADDR_CMD    = 2'd2;

  // Programmed valid region of the weight matrix
  typedef struct packed {
    cfg_data_t width;
    cfg_data_t height;
  } wbuf_geom_t;

  // One-cycle strobes from the host
  typedef struct packed {
    logic load;
    logic shift;
  } wbuf_cmd_t;

endpackage : wbuf_pkg

`default_nettype wire
